// ==== src/his_defines.svh ====
`ifndef HIS_DEFINES_SVH
`define HIS_DEFINES_SVH

// array geometry
`define HIS_PIXEL_NUM 4
`define HIS_BIN_NUM 16
`define HIS_PIXEL_W 2
`define HIS_BIN_W 4
// flat bin index, pixel in the upper bits
`define HIS_IDX_W 6

// tdc code to bin mapping
`define HIS_CODE_W 10
`define HIS_BIN_SHIFT 4

// acquisitions per finished histogram
`define HIS_ACQ_NUM 3
// bin counter width, saturating
`define HIS_COUNT_W 16

// axi4-lite register map, byte addresses
`define HIS_ADDR_STATUS 12'h000
`define HIS_ADDR_DROP 12'h004
`define HIS_ADDR_CTRL 12'h008
`define HIS_ADDR_BIN_BASE 12'h100

`endif

// ==== src/his_pkg.sv ====
`default_nettype none
`include "his_defines.svh"

package his_pkg;

    // word tags
    localparam logic [1:0] TAG_EVENT = 2'b01;
    localparam logic [1:0] TAG_MARKER = 2'b10;

    // axi response codes
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    // photon event view
    typedef struct packed {
        logic [1:0]             tag;
        logic [`HIS_PIXEL_W-1:0] pixel;
        logic [1:0]             rsvd;
        logic [`HIS_CODE_W-1:0] code;
    } his_event_t;

    // end of acquisition view
    typedef struct packed {
        logic [1:0] tag;
        logic [7:0] acq_id;
        logic [5:0] rsvd;
    } his_marker_t;

    // one stream word, two readings of the same 16 bits
    typedef union packed {
        his_event_t  ev;
        his_marker_t mk;
    } his_word_u;

    typedef enum logic {
        EV_HIT     = 1'b0,
        EV_ACQ_END = 1'b1
    } his_cmd_kind_e;

    // decoded command into the execute stage
    typedef struct packed {
        his_cmd_kind_e          kind;
        logic [`HIS_PIXEL_W-1:0] pixel;
        logic [`HIS_BIN_W-1:0]   bin;
        logic                   out_of_range;
        logic                   valid;
    } his_cmd_t;

    // master to slave
    typedef struct packed {
        logic [11:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic        wvalid;
        logic        bready;
        logic [11:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

endpackage

`default_nettype wire

// ==== src/his_event_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "his_defines.svh"

module his_event_decode (
    input  wire                       clk,
    input  wire                       res,
    input  wire his_pkg::his_word_u   word,
    input  wire                       ev_valid,
    input  wire                       ev_ready,
    output his_pkg::his_cmd_t         cmd
);

    // code bits left after dropping the fine part
    localparam int SHIFT_W = `HIS_CODE_W - `HIS_BIN_SHIFT;

    logic                     accept;
    logic                     tag_event;
    logic                     tag_marker;
    logic [SHIFT_W-1:0]       code_shift;
    logic                     valid_q;
    his_pkg::his_cmd_kind_e   kind_q;
    logic [`HIS_PIXEL_W-1:0]  pixel_q;
    logic [`HIS_BIN_W-1:0]    bin_q;
    logic                     oor_q;

    // stream handshake
    assign accept = ev_valid && ev_ready;

    // tag sits in the same bits for both views
    assign tag_event = (word.ev.tag == his_pkg::TAG_EVENT);
    assign tag_marker = (word.mk.tag == his_pkg::TAG_MARKER);

    // coarse time, still wider than a bin index
    assign code_shift = SHIFT_W'(word.ev.code >> `HIS_BIN_SHIFT);

    // command valid, unknown tags are swallowed
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept && (tag_event || tag_marker);
        end
    end

    // command payload
    always_ff @(posedge clk) begin
        if (accept) begin
            if (tag_marker) begin
                kind_q  <= his_pkg::EV_ACQ_END;
                pixel_q <= '0;
                bin_q   <= '0;
                oor_q   <= 1'b0;
            end else begin
                kind_q  <= his_pkg::EV_HIT;
                pixel_q <= word.ev.pixel;
                bin_q   <= code_shift[`HIS_BIN_W-1:0];
                // late photons land past the last bin
                oor_q   <= (code_shift >= SHIFT_W'(`HIS_BIN_NUM));
            end
        end
    end

    assign cmd = '{
        kind:         kind_q,
        pixel:        pixel_q,
        bin:          bin_q,
        out_of_range: oor_q,
        valid:        valid_q
    };

    // upstream keeps a blocked word and its valid until the word is taken
    a_word_held: assert property (
        @(posedge clk) disable iff (!res)
        (ev_valid && !ev_ready) |=> (ev_valid && $stable(word))
    );

endmodule

`default_nettype wire

// ==== src/his_bin_accumulate.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "his_defines.svh"

module his_bin_accumulate (
    input  wire                       clk,
    input  wire                       res,
    input  wire his_pkg::his_cmd_t    cmd,
    input  wire                       restart,
    input  wire [`HIS_IDX_W-1:0]      rd_idx,
    output logic                      ev_ready,
    output logic [`HIS_COUNT_W-1:0]   rd_count,
    output logic [7:0]                frame_count,
    output logic                      read_bank,
    output logic [15:0]               drop_count
);

    localparam int DEPTH = `HIS_PIXEL_NUM * `HIS_BIN_NUM;
    localparam int IDX_W = `HIS_IDX_W;
    localparam int ACQ_W = $clog2(`HIS_ACQ_NUM);
    localparam logic [ACQ_W-1:0] ACQ_LAST = ACQ_W'(`HIS_ACQ_NUM - 1);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DEPTH - 1);

    // two banks of bin counters, flops
    logic [`HIS_COUNT_W-1:0] bank_mem [2][DEPTH];

    logic                    ready_q;
    logic                    sweeping;
    logic [IDX_W-1:0]        sweep_idx;
    logic [ACQ_W-1:0]        acq_cnt;
    logic                    wr_bank;
    logic                    marker;
    logic                    last_marker;
    logic                    hit_wr;
    logic                    drop_wr;
    logic [IDX_W-1:0]        hit_idx;
    logic [`HIS_COUNT_W-1:0] hit_old;

    // writes always go to the bank the readout is not looking at
    assign wr_bank = ~read_bank;

    assign marker = cmd.valid && (cmd.kind == his_pkg::EV_ACQ_END);
    assign last_marker = marker && (acq_cnt == ACQ_LAST);
    assign hit_wr = cmd.valid && (cmd.kind == his_pkg::EV_HIT) && !cmd.out_of_range;
    assign drop_wr = cmd.valid && (cmd.kind == his_pkg::EV_HIT) && cmd.out_of_range;

    // flat index, pixel major
    assign hit_idx = {cmd.pixel, cmd.bin};
    assign hit_old = bank_mem[wr_bank][hit_idx];

    // readout port into the frozen bank
    assign rd_count = bank_mem[read_bank][rd_idx];

    // hold the stream off one cycle early so nothing lands in the sweep
    assign ev_ready = ready_q && !sweeping && !restart && !last_marker;

    // acquisition counting, bank swap and sweep control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ready_q     <= 1'b0;
            sweeping    <= 1'b0;
            sweep_idx   <= '0;
            acq_cnt     <= '0;
            frame_count <= '0;
            read_bank   <= 1'b0;
            drop_count  <= '0;
        end else begin
            ready_q <= 1'b1;
            if (restart) begin
                // restart wins over anything in flight
                acq_cnt    <= '0;
                drop_count <= '0;
                sweeping   <= 1'b1;
                sweep_idx  <= '0;
            end else if (sweeping) begin
                sweep_idx <= sweep_idx + 1'b1;
                if (sweep_idx == IDX_LAST) begin
                    sweeping <= 1'b0;
                end
            end else begin
                // dropped events, saturating
                if (drop_wr && (drop_count != '1)) begin
                    drop_count <= drop_count + 1'b1;
                end
                if (last_marker) begin
                    // frame done, freeze it and clear the other bank
                    acq_cnt     <= '0;
                    read_bank   <= ~read_bank;
                    frame_count <= frame_count + 1'b1;
                    sweeping    <= 1'b1;
                    sweep_idx   <= '0;
                end else if (marker) begin
                    acq_cnt <= acq_cnt + 1'b1;
                end
            end
        end
    end

    // bank storage, whole array cleared on reset
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < DEPTH; i++) begin
                    bank_mem[b][i] <= '0;
                end
            end
        end else if (sweeping) begin
            // one bin per cycle
            bank_mem[wr_bank][sweep_idx] <= '0;
        end else if (hit_wr && (hit_old != '1)) begin
            bank_mem[wr_bank][hit_idx] <= hit_old + 1'b1;
        end
    end

    // decode must stay quiet for the whole sweep
    a_no_hit_in_sweep: assert property (
        @(posedge clk) disable iff (!res)
        sweeping |-> !hit_wr
    );

    // bank swap only follows a marker
    a_swap_on_marker: assert property (
        @(posedge clk) disable iff (!res)
        $changed(read_bank) |-> $past(marker)
    );

endmodule

`default_nettype wire

// ==== src/his_axil_readout.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "his_defines.svh"

module his_axil_readout (
    input  wire                       clk,
    input  wire                       res,
    input  wire his_pkg::axil_req_t   axil_req,
    output his_pkg::axil_rsp_t        axil_rsp,
    input  wire [`HIS_COUNT_W-1:0]    rd_count,
    input  wire [7:0]                 frame_count,
    input  wire                       read_bank,
    input  wire [15:0]                drop_count,
    output logic [`HIS_IDX_W-1:0]     rd_idx,
    output logic                      restart
);

    localparam int DEPTH = `HIS_PIXEL_NUM * `HIS_BIN_NUM;
    localparam logic [11:0] BIN_END = `HIS_ADDR_BIN_BASE + 12'(4 * DEPTH);

    logic        init_q;
    logic        ar_ready;
    logic        ar_hs;
    logic        ar_bin;
    logic [11:0] ar_off;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic [1:0]  rresp_q;
    logic        aw_ready;
    logic        w_ready;
    logic        aw_hs;
    logic        w_hs;
    logic        aw_done;
    logic        w_done;
    logic [11:0] awaddr_q;
    logic [31:0] wdata_q;
    logic [11:0] wr_addr;
    logic [31:0] wr_data;
    logic        wr_fire;
    logic        wr_ctrl;
    logic        bvalid_q;
    logic [1:0]  bresp_q;
    logic        restart_q;

    // read address decode
    assign ar_ready = init_q && !rvalid_q;
    assign ar_hs = axil_req.arvalid && ar_ready;
    assign ar_bin = (axil_req.araddr >= `HIS_ADDR_BIN_BASE) && (axil_req.araddr < BIN_END);
    assign ar_off = axil_req.araddr - `HIS_ADDR_BIN_BASE;
    // word offset in the bin window
    assign rd_idx = ar_off[`HIS_IDX_W+1:2];

    always_comb begin
        rd_data = '0;
        rd_resp = his_pkg::AXI_RESP_OKAY;
        if (axil_req.araddr == `HIS_ADDR_STATUS) begin
            // bank in 16, frame count in 15:8, frame ready in 0
            rd_data = {15'b0, read_bank, frame_count, 7'b0, (frame_count != 8'd0)};
        end else if (axil_req.araddr == `HIS_ADDR_DROP) begin
            rd_data = 32'(drop_count);
        end else if (ar_bin) begin
            rd_data = 32'(rd_count);
        end else begin
            rd_resp = his_pkg::AXI_RESP_SLVERR;
        end
    end

    // write side, address and data may come in either order
    assign aw_ready = init_q && !aw_done && !bvalid_q;
    assign w_ready = init_q && !w_done && !bvalid_q;
    assign aw_hs = axil_req.awvalid && aw_ready;
    assign w_hs = axil_req.wvalid && w_ready;
    assign wr_addr = aw_done ? awaddr_q : axil_req.awaddr;
    assign wr_data = w_done ? wdata_q : axil_req.wdata;
    assign wr_fire = (aw_done || aw_hs) && (w_done || w_hs);
    // control register is the only writable location
    assign wr_ctrl = (wr_addr == `HIS_ADDR_CTRL);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            init_q    <= 1'b0;
            rvalid_q  <= 1'b0;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
            bvalid_q  <= 1'b0;
            restart_q <= 1'b0;
        end else begin
            init_q <= 1'b1;
            // read response held until taken
            if (ar_hs) begin
                rvalid_q <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
            // single cycle restart pulse
            restart_q <= wr_fire && wr_ctrl && wr_data[0];
            if (wr_fire) begin
                aw_done  <= 1'b0;
                w_done   <= 1'b0;
                bvalid_q <= 1'b1;
            end else begin
                if (aw_hs) begin
                    aw_done <= 1'b1;
                end
                if (w_hs) begin
                    w_done <= 1'b1;
                end
                if (bvalid_q && axil_req.bready) begin
                    bvalid_q <= 1'b0;
                end
            end
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
        if (aw_hs) begin
            awaddr_q <= axil_req.awaddr;
        end
        if (w_hs) begin
            wdata_q <= axil_req.wdata;
        end
        if (wr_fire) begin
            bresp_q <= wr_ctrl ? his_pkg::AXI_RESP_OKAY : his_pkg::AXI_RESP_SLVERR;
        end
    end

    assign restart = restart_q;

    assign axil_rsp = '{
        awready: aw_ready,
        wready:  w_ready,
        bresp:   bresp_q,
        bvalid:  bvalid_q,
        arready: ar_ready,
        rdata:   rdata_q,
        rresp:   rresp_q,
        rvalid:  rvalid_q
    };

    // read data frozen while the master stalls
    a_rdata_stable: assert property (
        @(posedge clk) disable iff (!res)
        (rvalid_q && !axil_req.rready) |=> ($stable(rdata_q) && $stable(rresp_q))
    );

endmodule

`default_nettype wire

// ==== src/his_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "his_defines.svh"

module his_top (
    input  wire                       clk,
    input  wire                       res,
    input  wire his_pkg::his_word_u   word,
    input  wire                       ev_valid,
    output logic                      ev_ready,
    input  wire his_pkg::axil_req_t   axil_req,
    output his_pkg::axil_rsp_t        axil_rsp
);

    // decode to execute
    his_pkg::his_cmd_t       cmd;

    // execute and readout
    logic [`HIS_IDX_W-1:0]   rd_idx;
    logic [`HIS_COUNT_W-1:0] rd_count;
    logic [7:0]              frame_count;
    logic                    read_bank;
    logic [15:0]             drop_count;
    logic                    restart;

    his_event_decode u_decode (
        .clk      (clk),
        .res      (res),
        .word     (word),
        .ev_valid (ev_valid),
        .ev_ready (ev_ready),
        .cmd      (cmd)
    );

    his_bin_accumulate u_accumulate (
        .clk         (clk),
        .res         (res),
        .cmd         (cmd),
        .restart     (restart),
        .rd_idx      (rd_idx),
        .ev_ready    (ev_ready),
        .rd_count    (rd_count),
        .frame_count (frame_count),
        .read_bank   (read_bank),
        .drop_count  (drop_count)
    );

    his_axil_readout u_readout (
        .clk         (clk),
        .res         (res),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .rd_count    (rd_count),
        .frame_count (frame_count),
        .read_bank   (read_bank),
        .drop_count  (drop_count),
        .rd_idx      (rd_idx),
        .restart     (restart)
    );

endmodule

`default_nettype wire

// ==== verif/his_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "his_defines.svh"

module his_tb;

    localparam int DEPTH = `HIS_PIXEL_NUM * `HIS_BIN_NUM;
    localparam int TIMEOUT = 200;

    logic               clk;
    logic               res;
    his_pkg::his_word_u word;
    logic               ev_valid;
    logic               ev_ready;
    his_pkg::axil_req_t axil_req;
    his_pkg::axil_rsp_t axil_rsp;

    integer seed;
    // random idle cycles on the stream and rready stalls
    logic   stall_on;

    // reference model
    logic [`HIS_COUNT_W-1:0] mdl_bank [2][DEPTH];
    int                      mdl_acq;
    logic [7:0]              mdl_frame;
    logic                    mdl_rb;
    logic [15:0]             mdl_drop;

    his_top u_his_top (
        .clk      (clk),
        .res      (res),
        .word     (word),
        .ev_valid (ev_valid),
        .ev_ready (ev_ready),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_count(input string name, input logic [`HIS_COUNT_W-1:0] exp,
                               input logic [`HIS_COUNT_W-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_status(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED: %s expected %h actual %h", name, exp, act));
        end
    endtask

    // status layout, frame ready in 0, frame count in 15:8, bank in 16
    function automatic logic [31:0] status_word();
        logic [31:0] s;
        s = '0;
        s[0] = (mdl_frame != 8'd0);
        s[15:8] = mdl_frame;
        s[16] = mdl_rb;
        return s;
    endfunction

    task automatic model_clear_write_bank();
        for (int i = 0; i < DEPTH; i++) begin
            mdl_bank[int'(!mdl_rb)][i] = '0;
        end
    endtask

    // applied once per word that the DUT accepted
    task automatic model_accept(input his_pkg::his_word_u w);
        int coarse;
        int idx;
        if (w.ev.tag == 2'b01) begin
            coarse = int'(w.ev.code >> `HIS_BIN_SHIFT);
            if (coarse >= `HIS_BIN_NUM) begin
                if (mdl_drop != 16'hffff) mdl_drop++;
            end else begin
                idx = int'(w.ev.pixel) * `HIS_BIN_NUM + coarse;
                if (mdl_bank[int'(!mdl_rb)][idx] != '1) begin
                    mdl_bank[int'(!mdl_rb)][idx]++;
                end
            end
        end else if (w.mk.tag == 2'b10) begin
            mdl_acq++;
            // frame complete, swap and clear the new write bank
            if (mdl_acq == `HIS_ACQ_NUM) begin
                mdl_acq = 0;
                mdl_rb = !mdl_rb;
                mdl_frame++;
                model_clear_write_bank();
            end
        end
    endtask

    // about a quarter out of range, some unknown tags
    function automatic his_pkg::his_word_u rand_event();
        his_pkg::his_word_u w;
        int sel;
        int coarse;
        sel = $random(seed) & 15;
        w.ev.pixel = 2'($random(seed));
        w.ev.rsvd = 2'($random(seed));
        if ((sel & 3) == 0) begin
            coarse = `HIS_BIN_NUM + (($random(seed) & 32'h7fffffff) % 48);
        end else begin
            coarse = $random(seed) & 15;
        end
        w.ev.code = {6'(coarse), 4'($random(seed))};
        if (sel == 1) w.ev.tag = 2'b00;
        else if (sel == 2) w.ev.tag = 2'b11;
        else w.ev.tag = 2'b01;
        return w;
    endfunction

    function automatic his_pkg::his_word_u marker_word(input logic [7:0] id);
        his_pkg::his_word_u w;
        w.mk.tag = 2'b10;
        w.mk.acq_id = id;
        w.mk.rsvd = '0;
        return w;
    endfunction

    task automatic wait_ev_ready();
        int n;
        n = 0;
        while (ev_ready !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_on_error("timeout waiting for ev_ready");
        end
    endtask

    // entered and left just after a falling edge
    task automatic send_word(input his_pkg::his_word_u w);
        int n;
        if (stall_on) begin
            while (($random(seed) & 3) == 0) begin
                ev_valid = 1'b0;
                word = 16'($random(seed));
                @(negedge clk);
            end
        end
        word = w;
        ev_valid = 1'b1;
        n = 0;
        // hold word and valid while the stream is blocked
        while (ev_ready !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_on_error("timeout waiting for ev_ready");
        end
        @(posedge clk);
        model_accept(w);
        @(negedge clk);
        ev_valid = 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        axil_req.araddr = addr;
        axil_req.arvalid = 1'b1;
        n = 0;
        while (axil_rsp.arready !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_on_error("timeout waiting for arready");
        end
        @(posedge clk);
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        n = 0;
        forever begin
            axil_req.rready = stall_on ? 1'($random(seed)) : 1'b1;
            if (axil_rsp.rvalid === 1'b1 && axil_req.rready) break;
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_on_error("timeout waiting for rvalid");
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge clk);
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int   n;
        logic aw_take;
        logic w_take;
        axil_req.awaddr = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata = data;
        axil_req.wvalid = 1'b1;
        axil_req.bready = 1'b1;
        n = 0;
        // address and data channels may complete on different edges
        while (axil_req.awvalid || axil_req.wvalid) begin
            aw_take = axil_req.awvalid && (axil_rsp.awready === 1'b1);
            w_take = axil_req.wvalid && (axil_rsp.wready === 1'b1);
            @(posedge clk);
            @(negedge clk);
            if (aw_take) axil_req.awvalid = 1'b0;
            if (w_take) axil_req.wvalid = 1'b0;
            n++;
            if (n > TIMEOUT) stop_on_error("timeout waiting for awready and wready");
        end
        n = 0;
        while (axil_rsp.bvalid !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_on_error("timeout waiting for bvalid");
        end
        resp = axil_rsp.bresp;
        @(posedge clk);
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic read_reg(input string name, input logic [11:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check_resp({name, " resp"}, his_pkg::AXI_RESP_OKAY, resp);
        check_status(name, exp, data);
    endtask

    task automatic read_bin(input string name, input int idx);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(`HIS_ADDR_BIN_BASE + 12'(4 * idx), data, resp);
        check_resp({name, " resp"}, his_pkg::AXI_RESP_OKAY, resp);
        check_count(name, mdl_bank[int'(mdl_rb)][idx], data[`HIS_COUNT_W-1:0]);
        // bin counts are zero extended on the bus
        check_status({name, " upper bits"}, 32'h0, 32'(data[31:`HIS_COUNT_W]));
    endtask

    // whole read bank plus both registers
    task automatic verify_readout(input string name);
        for (int i = 0; i < DEPTH; i++) begin
            read_bin($sformatf("%s bin %0d", name, i), i);
        end
        read_reg({name, " status"}, `HIS_ADDR_STATUS, status_word());
        read_reg({name, " dropped"}, `HIS_ADDR_DROP, {16'b0, mdl_drop});
    endtask

    // events then one marker, optional bin reads between words
    task automatic send_acq(input int n_events, input logic peek);
        for (int k = 0; k < n_events; k++) begin
            send_word(rand_event());
            if (peek && (($random(seed) & 1) == 1)) begin
                read_bin("between words", $random(seed) & (DEPTH - 1));
            end
        end
        send_word(marker_word(8'(mdl_acq)));
    endtask

    task automatic send_frame(input logic peek);
        for (int a = 0; a < `HIS_ACQ_NUM; a++) begin
            send_acq(16 + ($random(seed) & 31), peek);
        end
        // sweep of the new write bank
        wait_ev_ready();
    endtask

    initial begin
        his_pkg::his_word_u w;
        logic [31:0]        data;
        logic [1:0]         resp;
        seed = 98;
        stall_on = 1'b0;
        res = 1'b0;
        word = '0;
        ev_valid = 1'b0;
        axil_req = '0;
        for (int i = 0; i < DEPTH; i++) begin
            mdl_bank[0][i] = '0;
            mdl_bank[1][i] = '0;
        end
        mdl_acq = 0;
        mdl_frame = '0;
        mdl_rb = 1'b0;
        mdl_drop = '0;
        repeat (3) @(negedge clk);
        res = 1'b1;

        // everything zero out of reset
        verify_readout("reset");

        // first frame
        send_frame(1'b0);
        verify_readout("frame one");
        read_reg("frame one status literal", `HIS_ADDR_STATUS, 32'h0001_0101);

        // second frame with reads of the frozen bank in between
        send_frame(1'b1);
        verify_readout("frame two");
        read_reg("frame two status literal", `HIS_ADDR_STATUS, 32'h0000_0201);

        // one bin driven past full scale, pixel 2 bin 5
        w.ev.tag = 2'b01;
        w.ev.pixel = 2'd2;
        w.ev.rsvd = 2'b00;
        w.ev.code = {6'd5, 4'd9};
        repeat (65540) send_word(w);
        for (int a = 0; a < `HIS_ACQ_NUM; a++) begin
            send_word(marker_word(8'(a)));
        end
        wait_ev_ready();
        verify_readout("saturation");
        axil_read(`HIS_ADDR_BIN_BASE + 12'(4 * (2 * `HIS_BIN_NUM + 5)), data, resp);
        check_count("saturated bin", 16'hffff, data[`HIS_COUNT_W-1:0]);

        // error responses leave state alone
        axil_read(12'h00c, data, resp);
        check_resp("unmapped 0x00c", his_pkg::AXI_RESP_SLVERR, resp);
        axil_read(12'h0fc, data, resp);
        check_resp("unmapped 0x0fc", his_pkg::AXI_RESP_SLVERR, resp);
        axil_read(12'h200, data, resp);
        check_resp("unmapped 0x200", his_pkg::AXI_RESP_SLVERR, resp);
        axil_read(12'hffc, data, resp);
        check_resp("unmapped 0xffc", his_pkg::AXI_RESP_SLVERR, resp);
        axil_write(`HIS_ADDR_STATUS, 32'hffff_ffff, resp);
        check_resp("status write", his_pkg::AXI_RESP_SLVERR, resp);
        verify_readout("after errors");

        // partial acquisition, then restart
        send_acq(20, 1'b0);
        axil_write(`HIS_ADDR_CTRL, 32'h0000_0001, resp);
        check_resp("restart write", his_pkg::AXI_RESP_OKAY, resp);
        mdl_acq = 0;
        mdl_drop = '0;
        model_clear_write_bank();
        verify_readout("after restart");
        send_frame(1'b0);
        verify_readout("frame after restart");

        // idle gaps on the stream, rready stalls on reads
        stall_on = 1'b1;
        send_frame(1'b1);
        verify_readout("stalled stream");
        stall_on = 1'b0;

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+src
src/his_pkg.sv
src/his_event_decode.sv
src/his_bin_accumulate.sv
src/his_axil_readout.sv
src/his_top.sv
verif/his_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the histogram testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module his_tb --Mdir obj_dir -o his_sim \
    -f verilog.f \
    && ./obj_dir/his_sim \
    || { echo "simulation failed"; exit 1; }
